/* Bender.yml */
package:
  name: fpu_result_path

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_req_pkg.sv
      - source/fpu_out_pkg.sv
      - source/fpu_issue.sv
      - source/fpu_exec_pipe.sv
      - source/fpu_out_ctl.sv
      - source/fpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/fpu_clk_gen.sv
      - test/fpu_top_tb.sv

/* project.f */
+incdir+source
source/fpu_req_pkg.sv
source/fpu_out_pkg.sv
source/fpu_issue.sv
source/fpu_exec_pipe.sv
source/fpu_out_ctl.sv
source/fpu_top.sv
test/fpu_clk_gen.sv
test/fpu_top_tb.sv

/* source/fpu_defines.svh */
// Pipe count, pipe latencies and field widths of the integer FPU result path, include anywhere
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Execution pipes
//////////////////////////////////////////////////////////////////////

`define FPU_NUM_PIPES 3 // Add, multiply and divide

// Stage counts of the pipes
`define FPU_ADD_LAT 4 // Add pipe
`define FPU_MUL_LAT 6 // Multiply pipe, as the m6 stages
`define FPU_DIV_LAT 8 // Divide pipe, as the d8 stages

//////////////////////////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////////////////////////

`define FPU_WORD_W   32 // Operand and result word
`define FPU_TAG_W    8  // Request tag
`define FPU_THREAD_W 2  // Thread number

// ID is the tag above the thread
`define FPU_ID_W (`FPU_TAG_W + `FPU_THREAD_W)

`endif

/* source/fpu_exec_pipe.sv */
// Fixed-latency execution pipe of the FPU, one instance per operation, stalls as a whole when held
`timescale 1ns/1ns
`default_nettype none

module fpu_exec_pipe
	import fpu_req_pkg::*;
#(
	parameter int      LATENCY = 4,     // Number of stages
	parameter fpu_op_t OP      = op_add // Operation of this pipe
) (
	input  logic      rclk,
	input  logic      rst_n,

	// From issue
	input  logic      pipe_in_valid,
	output logic      pipe_in_ready,
	input  fpu_word_t pipe_in_a,
	input  fpu_word_t pipe_in_b,
	input  fpu_id_t   pipe_in_id,

	// To output control
	output logic      res_valid,
	input  logic      res_ready,   // Grant of this cycle
	output fpu_id_t   res_id,
	output fpu_word_t res_data
);

	logic      stg_valid [LATENCY]; // Index 0 is stage one
	fpu_id_t   stg_id    [LATENCY];
	fpu_word_t stg_data  [LATENCY];
	fpu_word_t calc;                // Stage one result
	logic      advance;             // Whole chain moves

	//////////////////////////////////////////////////////////////////////
	// Stage one arithmetic
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (OP)
			op_add: calc = pipe_in_a + pipe_in_b;
			op_mul: calc = pipe_in_a * pipe_in_b; // Low word kept
			op_div: begin
				// Zero divisor gives all ones
				if (pipe_in_b == '0)
					calc = '1;
				else
					calc = pipe_in_a / pipe_in_b;
			end
			default: calc = '0;
		endcase
	end

	// Held only when the last stage waits for its grant
	assign advance = !(stg_valid[LATENCY-1] && !res_ready);

	// Empty stage one can still load during a stall
	assign pipe_in_ready = advance || !stg_valid[0];

	//////////////////////////////////////////////////////////////////////
	// Stage chain
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			for (int k = 0; k < LATENCY; k++) begin
				stg_valid[k] <= 1'b0;
			end
		end else begin
			if (pipe_in_ready)
				stg_valid[0] <= pipe_in_valid; // Bubble when idle
			if (advance) begin
				for (int k = 1; k < LATENCY; k++) begin
					stg_valid[k] <= stg_valid[k-1];
				end
			end
		end
	end

	always_ff @(posedge rclk) begin
		if (pipe_in_ready && pipe_in_valid) begin
			stg_id[0]   <= pipe_in_id;
			stg_data[0] <= calc;
		end
		if (advance) begin
			for (int k = 1; k < LATENCY; k++) begin
				stg_id[k]   <= stg_id[k-1];
				stg_data[k] <= stg_data[k-1];
			end
		end
	end

	// Last stage drives the result request
	assign res_valid = stg_valid[LATENCY-1];
	assign res_id    = stg_id[LATENCY-1];
	assign res_data  = stg_data[LATENCY-1];

endmodule

`default_nettype wire

/* source/fpu_issue.sv */
// Issue stage of the FPU, holds one request and offers it to the pipe that its operation selects
`timescale 1ns/1ns
`default_nettype none

`include "fpu_defines.svh"

module fpu_issue
	import fpu_req_pkg::*, fpu_out_pkg::*;
(
	input  logic      rclk,
	input  logic      rst_n,

	// Request from the core
	input  logic      in_valid,
	output logic      in_ready,
	input  fpu_op_t   in_op,
	input  fpu_word_t in_a,
	input  fpu_word_t in_b,
	input  fpu_id_t   in_id,

	// Shared request bus to the pipes, one valid/ready pair per pipe
	output logic      pipe_in_valid [`FPU_NUM_PIPES],
	input  logic      pipe_in_ready [`FPU_NUM_PIPES],
	output fpu_word_t pipe_in_a,
	output fpu_word_t pipe_in_b,
	output fpu_id_t   pipe_in_id
);

	logic       hold_valid; // Holding register occupied
	fpu_op_t    hold_op;
	fpu_word_t  hold_a;
	fpu_word_t  hold_b;
	fpu_id_t    hold_id;
	fpu_pipe_t  hold_pipe;  // Pipe picked by the stored operation
	logic       take;       // Target pipe accepts this cycle
	logic       accept;     // New request loads this cycle

	//////////////////////////////////////////////////////////////////////
	// Pipe decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (hold_op)
			op_add:  hold_pipe = pipe_add;
			op_mul:  hold_pipe = pipe_mul;
			default: hold_pipe = pipe_div; // Spare code falls to divide
		endcase
	end

	// Only the decoded pipe sees valid
	always_comb begin
		for (int k = 0; k < `FPU_NUM_PIPES; k++) begin
			pipe_in_valid[k] = hold_valid && (hold_pipe == fpu_pipe_t'(k));
		end
	end

	assign take     = hold_valid && pipe_in_ready[hold_pipe];
	assign in_ready = !hold_valid || take; // Empty, or emptying now
	assign accept   = in_valid && in_ready;

	assign pipe_in_a  = hold_a;
	assign pipe_in_b  = hold_b;
	assign pipe_in_id = hold_id;

	//////////////////////////////////////////////////////////////////////
	// Holding register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
		end else if (accept) begin
			hold_valid <= 1'b1; // Refill wins over drain
		end else if (take) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge rclk) begin
		if (accept) begin
			hold_op <= in_op;
			hold_a  <= in_a;
			hold_b  <= in_b;
			hold_id <= in_id;
		end
	end

endmodule

`default_nettype wire

/* source/fpu_out_ctl.sv */
// FPU output control, grants the single result port to one pipe and registers the result request
`timescale 1ns/1ns
`default_nettype none

`include "fpu_defines.svh"

module fpu_out_ctl
	import fpu_req_pkg::*, fpu_out_pkg::*;
(
	input  logic        rclk,
	input  logic        rst_n,

	// Result requests from the pipes
	input  logic        res_valid [`FPU_NUM_PIPES],
	input  fpu_id_t     res_id    [`FPU_NUM_PIPES],
	input  fpu_word_t   res_data  [`FPU_NUM_PIPES],
	output logic        res_ready [`FPU_NUM_PIPES], // Same-cycle grant

	// Registered result port
	output logic        out_valid,
	output fpu_dest_t   out_dest,   // Winning pipe, one-hot
	output fpu_tag_t    out_tag,
	output fpu_thread_t out_thread,
	output fpu_word_t   out_data
);

	logic      add_turn;  // Round-robin pointer, set favours add
	logic      div_sel;
	logic      mul_sel;
	logic      add_sel;
	logic      rr_step;   // Add or multiply won
	fpu_dest_t dest_in;
	fpu_id_t   sel_id;
	fpu_word_t sel_data;

	//////////////////////////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////////////////////////

	assign div_sel = res_valid[pipe_div]; // Divide always wins

	// Multiply and add take turns below divide
	assign mul_sel = res_valid[pipe_mul]
		&& (!add_turn || !res_valid[pipe_add])
		&& !div_sel;

	assign add_sel = res_valid[pipe_add]
		&& (add_turn || !res_valid[pipe_mul])
		&& !div_sel;

	assign rr_step = add_sel || mul_sel;

	always_ff @(posedge rclk) begin
		if (!rst_n)
			add_turn <= 1'b0; // Multiply first after reset
		else if (rr_step)
			add_turn <= !add_turn;
	end

	// Grant goes straight back to the pipes
	assign res_ready[pipe_div] = div_sel;
	assign res_ready[pipe_mul] = mul_sel;
	assign res_ready[pipe_add] = add_sel;

	//////////////////////////////////////////////////////////////////////
	// Winner select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		dest_in           = '0;
		dest_in[pipe_div] = div_sel;
		dest_in[pipe_mul] = mul_sel;
		dest_in[pipe_add] = add_sel;
	end

	// AND-OR select, grants are one-hot
	assign sel_id = ({`FPU_ID_W{div_sel}} & res_id[pipe_div])
		| ({`FPU_ID_W{mul_sel}} & res_id[pipe_mul])
		| ({`FPU_ID_W{add_sel}} & res_id[pipe_add]);

	assign sel_data = ({`FPU_WORD_W{div_sel}} & res_data[pipe_div])
		| ({`FPU_WORD_W{mul_sel}} & res_data[pipe_mul])
		| ({`FPU_WORD_W{add_sel}} & res_data[pipe_add]);

	//////////////////////////////////////////////////////////////////////
	// Result request register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_dest  <= '0;
		end else begin
			out_valid <= |dest_in; // Any grant
			out_dest  <= dest_in;
		end
	end

	// Split the ID into tag and thread
	always_ff @(posedge rclk) begin
		out_tag    <= sel_id[`FPU_ID_W-1:`FPU_THREAD_W];
		out_thread <= sel_id[`FPU_THREAD_W-1:0];
		out_data   <= sel_data;
	end

endmodule

`default_nettype wire

/* source/fpu_out_pkg.sv */
// Result-side types of the FPU result path, imported where pipes are named or selected one-hot
`default_nettype none

`include "fpu_defines.svh"

package fpu_out_pkg;

	// Pipe indexes, shared by the valid/ready arrays and the one-hot select
	typedef enum logic [1:0] {
		pipe_add = 2'd0, // Lowest bit of the select
		pipe_mul = 2'd1,
		pipe_div = 2'd2  // Highest bit of the select
	} fpu_pipe_t;

	// One-hot pipe that owns the result
	// Bit order div, mul, add from the top down
	typedef logic [`FPU_NUM_PIPES-1:0] fpu_dest_t;

endpackage

`default_nettype wire

/* source/fpu_req_pkg.sv */
// Request-side types of the FPU result path, imported by the issue logic, the pipes and the top
`default_nettype none

`include "fpu_defines.svh"

package fpu_req_pkg;

	// Operation carried by a request, one per execution pipe
	typedef enum logic [1:0] {
		op_add = 2'd0, // Plain sum
		op_mul = 2'd1, // Low half of the product
		op_div = 2'd2  // Unsigned quotient
	} fpu_op_t;

	typedef logic [`FPU_WORD_W-1:0] fpu_word_t; // Operand or result

	typedef logic [`FPU_TAG_W-1:0] fpu_tag_t; // Request tag

	typedef logic [`FPU_THREAD_W-1:0] fpu_thread_t; // Issuing thread

	// Request ID
	// Tag sits in the upper bits and the thread in the low two
	typedef logic [`FPU_ID_W-1:0] fpu_id_t;

endpackage

`default_nettype wire

/* source/fpu_top.sv */
// Top of the integer FPU result path, joins issue, the three execution pipes and output control
`timescale 1ns/1ns
`default_nettype none

`include "fpu_defines.svh"

module fpu_top
	import fpu_req_pkg::*, fpu_out_pkg::*;
(
	input  logic        rclk,
	input  logic        rst_n,

	// Request port
	input  logic        in_valid,
	output logic        in_ready,
	input  fpu_op_t     in_op,
	input  fpu_word_t   in_a,
	input  fpu_word_t   in_b,
	input  fpu_id_t     in_id,

	// Result port, always taken
	output logic        out_valid,
	output fpu_dest_t   out_dest,
	output fpu_tag_t    out_tag,
	output fpu_thread_t out_thread,
	output fpu_word_t   out_data
);

	// Issue to pipes
	logic      pipe_in_valid [`FPU_NUM_PIPES];
	logic      pipe_in_ready [`FPU_NUM_PIPES];
	fpu_word_t pipe_in_a;
	fpu_word_t pipe_in_b;
	fpu_id_t   pipe_in_id;

	// Pipes to output control
	logic      res_valid [`FPU_NUM_PIPES];
	logic      res_ready [`FPU_NUM_PIPES];
	fpu_id_t   res_id    [`FPU_NUM_PIPES];
	fpu_word_t res_data  [`FPU_NUM_PIPES];

	fpu_issue i_issue (
		.rclk          (rclk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_op         (in_op),
		.in_a          (in_a),
		.in_b          (in_b),
		.in_id         (in_id),
		.pipe_in_valid (pipe_in_valid),
		.pipe_in_ready (pipe_in_ready),
		.pipe_in_a     (pipe_in_a),
		.pipe_in_b     (pipe_in_b),
		.pipe_in_id    (pipe_in_id)
	);

	//////////////////////////////////////////////////////////////////////
	// Execution pipes, latency and operation follow the pipe index
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `FPU_NUM_PIPES; i++) begin : g_pipe
		localparam int PIPE_LAT = (i == pipe_div) ? `FPU_DIV_LAT :
			(i == pipe_mul) ? `FPU_MUL_LAT : `FPU_ADD_LAT;
		localparam fpu_op_t PIPE_OP = fpu_op_t'((i == pipe_div) ? op_div :
			(i == pipe_mul) ? op_mul : op_add);

		fpu_exec_pipe #(
			.LATENCY (PIPE_LAT),
			.OP      (PIPE_OP)
		) i_pipe (
			.rclk          (rclk),
			.rst_n         (rst_n),
			.pipe_in_valid (pipe_in_valid[i]),
			.pipe_in_ready (pipe_in_ready[i]),
			.pipe_in_a     (pipe_in_a),     // Shared operand bus
			.pipe_in_b     (pipe_in_b),
			.pipe_in_id    (pipe_in_id),
			.res_valid     (res_valid[i]),
			.res_ready     (res_ready[i]),
			.res_id        (res_id[i]),
			.res_data      (res_data[i])
		);
	end

	fpu_out_ctl i_out_ctl (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.res_valid  (res_valid),
		.res_id     (res_id),
		.res_data   (res_data),
		.res_ready  (res_ready),
		.out_valid  (out_valid),
		.out_dest   (out_dest),
		.out_tag    (out_tag),
		.out_thread (out_thread),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

/* test/fpu_clk_gen.sv */
// Testbench clock source for the FPU result path, free-running from time zero
`timescale 1ns/1ns
`default_nettype none

module fpu_clk_gen #(
	parameter int PERIOD_NS = 100 // Full clock period
) (
	output logic rclk
);

	// Low for the first half period, then toggles forever
	initial begin
		rclk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) rclk = ~rclk;
		end
	end

endmodule

`default_nettype wire

/* test/fpu_top_tb.sv */
// Testbench of the FPU result path, drives fpu_top with directed and random traffic and checks it
`timescale 1ns/1ns
`default_nettype none

`include "fpu_defines.svh"

module fpu_top_tb
	import fpu_req_pkg::*, fpu_out_pkg::*;
;

	localparam int N_TAGS      = 2 ** `FPU_TAG_W;
	localparam int N_RAND      = 120;                 // Mixed traffic to all pipes
	localparam int N_RR        = 80;                  // Add and multiply only
	localparam int NUM_REQ     = 4 + N_RAND + N_RR;   // Lone requests come first
	localparam int TIMEOUT_CYC = NUM_REQ * `FPU_DIV_LAT + 100;
	localparam int RAND_SEED   = 59499;

	logic        rclk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	fpu_op_t     in_op;
	fpu_word_t   in_a;
	fpu_word_t   in_b;
	fpu_id_t     in_id;
	logic        out_valid;
	fpu_dest_t   out_dest;
	fpu_tag_t    out_tag;
	fpu_thread_t out_thread;
	fpu_word_t   out_data;

	// Reference model, indexed by tag
	logic        exp_valid  [N_TAGS];
	fpu_op_t     exp_op     [N_TAGS];
	fpu_word_t   exp_data   [N_TAGS];
	fpu_thread_t exp_thread [N_TAGS];
	int          acc_cycle  [N_TAGS]; // Cycle of the input transfer
	int          ahead      [N_TAGS]; // Older items of the same pipe at acceptance
	fpu_tag_t    add_q [$];           // Pending tags per pipe, oldest first
	fpu_tag_t    mul_q [$];
	fpu_tag_t    div_q [$];

	int          cycle;
	int          pending;             // Accepted and not yet seen at the output
	int          next_tag;
	logic        lone_mode;           // Idle design, exact latency checked
	logic        rr_mode;             // No divides, round-robin checked
	logic        have_last;
	fpu_op_t     last_op;             // Last add or multiply result

	fpu_clk_gen #(.PERIOD_NS(100)) i_clk_gen (.rclk(rclk));

	fpu_top UUT (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.in_id      (in_id),
		.out_valid  (out_valid),
		.out_dest   (out_dest),
		.out_tag    (out_tag),
		.out_thread (out_thread),
		.out_data   (out_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Model rules
	//////////////////////////////////////////////////////////////////////

	function automatic fpu_word_t model_result(fpu_op_t op, fpu_word_t a, fpu_word_t b);
		logic [2*`FPU_WORD_W-1:0] prod;
		prod = {{`FPU_WORD_W{1'b0}}, a} * {{`FPU_WORD_W{1'b0}}, b};
		case (op)
			op_add:  return a + b;                       // Carry out dropped
			op_mul:  return prod[`FPU_WORD_W-1:0];       // Low word only
			default: return (b == '0) ? '1 : (a / b);    // Zero divisor gives all ones
		endcase
	endfunction

	function automatic int lat_of(fpu_op_t op);
		case (op)
			op_add:  return `FPU_ADD_LAT;
			op_mul:  return `FPU_MUL_LAT;
			default: return `FPU_DIV_LAT;
		endcase
	endfunction

	// One-hot select, div mul add from the top
	function automatic fpu_dest_t dest_of(fpu_op_t op);
		case (op)
			op_add:  return 3'b001;
			op_mul:  return 3'b010;
			default: return 3'b100;
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, sig,
			exp_val, act_val);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("** Error at %0t ns: %s", $time, what);
		$display("Verification failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Holds the request until the transfer edge
	task automatic send_req(input fpu_op_t op, input fpu_word_t a, input fpu_word_t b);
		fpu_thread_t th;
		th = fpu_thread_t'($urandom % 4);
		in_valid <= 1'b1;
		in_op    <= op;
		in_a     <= a;
		in_b     <= b;
		in_id    <= {fpu_tag_t'(next_tag), th};
		next_tag++;
		do @(posedge rclk); while (!in_ready);
		in_valid <= 1'b0;
	endtask

	// Called on the transfer edge of the last request
	task automatic wait_drain();
		@(posedge rclk);      // Monitor has counted the last request by now
		wait (pending == 0); // Timeout in the monitor ends a hang
	endtask

	initial begin
		fpu_op_t   op;
		fpu_word_t b;
		void'($urandom(RAND_SEED));
		rst_n     <= 1'b0;
		in_valid  <= 1'b0;
		in_op     <= op_add;
		in_a      <= '0;
		in_b      <= '0;
		in_id     <= '0;
		next_tag  = 0;
		lone_mode = 1'b1;
		rr_mode   = 1'b0;
		have_last = 1'b0;
		repeat (4) @(posedge rclk);
		rst_n <= 1'b1;
		@(posedge rclk);
		assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
		assert (in_ready == 1'b1) else report_mismatch("in_ready", 1, in_ready);

		// One lone request per pipe, then a zero divisor
		send_req(op_add, 32'hffff_fff0, 32'h0000_0025);
		wait_drain();
		send_req(op_mul, 32'h0001_2345, 32'h0004_0021);
		wait_drain();
		send_req(op_div, 32'hdead_beef, 32'h0000_0107);
		wait_drain();
		send_req(op_div, 32'h1234_5678, 32'h0);
		wait_drain();
		lone_mode = 1'b0;

		// Saturating mixed traffic, small divisors now and then
		for (int k = 0; k < N_RAND; k++) begin
			op = fpu_op_t'($urandom % 3);
			b  = ($urandom % 4 == 0) ? fpu_word_t'($urandom % 8) : fpu_word_t'($urandom);
			send_req(op, $urandom, b);
		end
		wait_drain();

		// Back-to-back add and multiply
		have_last = 1'b0;
		rr_mode   = 1'b1;
		for (int k = 0; k < N_RR; k++) begin
			op = ($urandom % 2 == 0) ? op_add : op_mul;
			send_req(op, $urandom, $urandom);
		end
		wait_drain();
		rr_mode = 1'b0;

		$display("Verification passed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Monitor and scoreboard
	//////////////////////////////////////////////////////////////////////

	initial begin
		cycle   = 0;
		pending = 0;
		for (int k = 0; k < N_TAGS; k++) begin
			exp_valid[k] = 1'b0;
		end
	end

	always @(posedge rclk) begin : monitor
		fpu_op_t  op;
		fpu_tag_t tag;
		fpu_tag_t w;
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYC) begin
			$display("Timeout: scoreboard still holds %0d results after %0d cycles",
				pending, cycle);
			$display("Verification failed");
			$fatal(1);
		end else if (rst_n) begin
			if (out_valid) begin
				assert (exp_valid[out_tag])
					else report_failure($sformatf("Result tag 0x%0h was never issued", out_tag));
				op = exp_op[out_tag];
				assert (out_data == exp_data[out_tag])
					else report_mismatch("out_data", exp_data[out_tag], out_data);
				assert (out_thread == exp_thread[out_tag])
					else report_mismatch("out_thread", exp_thread[out_tag], out_thread);
				assert (out_dest == dest_of(op))
					else report_mismatch("out_dest", dest_of(op), out_dest);
				// Same pipe keeps acceptance order
				case (op)
					op_add:  w = add_q.pop_front();
					op_mul:  w = mul_q.pop_front();
					default: w = div_q.pop_front();
				endcase
				assert (w == out_tag) else report_mismatch("out_tag", w, out_tag);
				if (lone_mode) begin
					assert (cycle - acc_cycle[out_tag] == lat_of(op) + 2)
						else report_mismatch("out_valid latency", lat_of(op) + 2,
							cycle - acc_cycle[out_tag]);
				end
				// Other pipe sure to sit in its last stage, allowing one stall per older item
				if (rr_mode && op != op_div) begin
					if (have_last && last_op == op && op == op_add && mul_q.size() > 0) begin
						w = mul_q[0];
						assert (cycle - acc_cycle[w] < `FPU_MUL_LAT + 2 + ahead[w])
							else report_failure($sformatf(
								"Two add results in a row while multiply tag 0x%0h waited", w));
					end
					if (have_last && last_op == op && op == op_mul && add_q.size() > 0) begin
						w = add_q[0];
						assert (cycle - acc_cycle[w] < `FPU_ADD_LAT + 2 + ahead[w])
							else report_failure($sformatf(
								"Two multiply results in a row while add tag 0x%0h waited", w));
					end
					have_last = 1'b1;
					last_op   = op;
				end
				exp_valid[out_tag] = 1'b0;
				pending--;
			end
			if (in_valid && in_ready) begin
				tag = in_id[`FPU_ID_W-1:`FPU_THREAD_W];
				exp_valid[tag]  = 1'b1;
				exp_op[tag]     = in_op;
				exp_data[tag]   = model_result(in_op, in_a, in_b);
				exp_thread[tag] = in_id[`FPU_THREAD_W-1:0];
				acc_cycle[tag]  = cycle;
				case (in_op)
					op_add: begin
						ahead[tag] = add_q.size();
						add_q.push_back(tag);
					end
					op_mul: begin
						ahead[tag] = mul_q.size();
						mul_q.push_back(tag);
					end
					default: begin
						ahead[tag] = div_q.size();
						div_q.push_back(tag);
					end
				endcase
				pending++;
			end
		end
	end

endmodule

`default_nettype wire
